//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build folder and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -j 0 -f flist.f --top-module tb_soc_bus -Mdir obj_dir
	-./obj_dir/Vtb_soc_bus > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || (echo "no pass line in log"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- flist.f
+incdir+source
source/soc_bus_pkg.sv
source/bus_arbiter.sv
source/clint_timer.sv
source/uart_tx_reg.sv
source/soc_bus_top.sv
verif/tb_axi_mem.sv
verif/tb_soc_bus.sv

//--- source/bus_arbiter.sv
`include "soc_bus_defines.svh"

module bus_arbiter (
  input  logic                 clk,
  input  logic                 rst,
  input  soc_bus_pkg::rd_req_t ifu_req_i,
  output soc_bus_pkg::rd_rsp_t ifu_rsp_o,
  input  soc_bus_pkg::rd_req_t lsu_rd_req_i,
  output soc_bus_pkg::rd_rsp_t lsu_rd_rsp_o,
  input  soc_bus_pkg::wr_req_t lsu_wr_req_i,
  output logic                 lsu_wr_done_o,
  output soc_bus_pkg::axi_ar_t axi_ar_o,
  input  logic                 axi_arready_i,
  input  soc_bus_pkg::axi_r_t  axi_r_i,
  output logic                 axi_rready_o,
  output soc_bus_pkg::axi_aw_t axi_aw_o,
  input  logic                 axi_awready_i,
  output soc_bus_pkg::axi_w_t  axi_w_o,
  input  logic                 axi_wready_i,
  input  soc_bus_pkg::axi_b_t  axi_b_i,
  output logic                 axi_bready_o,
  output soc_bus_pkg::rd_req_t timer_rd_req_o,
  input  soc_bus_pkg::rd_rsp_t timer_rsp_i,
  output soc_bus_pkg::wr_req_t uart_wr_o,
  input  logic                 uart_done_i
);

  // read channel owner
  localparam logic [1:0] OWN_IDLE = 2'd0;
  localparam logic [1:0] OWN_IFU  = 2'd1;
  localparam logic [1:0] OWN_LSU  = 2'd2;
  localparam logic [1:0] OWN_TMR  = 2'd3;

  logic [1:0]             rd_owner_q;
  logic                   ar_hold_q;
  logic                   ar_hold_lsu_q;
  logic                   aw_sent_q;
  logic                   w_sent_q;
  logic                   lsu_is_tmr;
  logic                   wr_is_uart;
  logic                   wr_to_mem;
  logic                   rd_idle;
  logic                   pick_lsu;
  logic                   timer_go;
  logic                   rd_lane_hi;
  logic [`SOC_DATA_W-1:0] r_word;
  soc_bus_pkg::rd_req_t   ar_src;

  // axi size from the byte mask: 1, 2 or 4 bytes
  function automatic logic [2:0] strb_to_size(input logic [`SOC_DATA_W/8-1:0] strb);
    case (strb)
      4'h3:    strb_to_size = 3'd1;
      4'hf:    strb_to_size = 3'd2;
      default: strb_to_size = 3'd0;
    endcase
  endfunction

  // address decode
  assign lsu_is_tmr = (lsu_rd_req_i.addr == `SOC_RTC_ADDR) ||
                      (lsu_rd_req_i.addr == `SOC_RTC_ADDR_UP);
  assign wr_is_uart = (lsu_wr_req_i.addr == `SOC_SERIAL_ADDR);
  assign wr_to_mem  = lsu_wr_req_i.valid & ~wr_is_uart;

  // load wins only if no ar is already being presented for the fetch
  assign rd_idle  = (rd_owner_q == OWN_IDLE);
  assign pick_lsu = ar_hold_q ? ar_hold_lsu_q : lsu_rd_req_i.valid;
  assign ar_src   = pick_lsu ? lsu_rd_req_i : ifu_req_i;
  assign timer_go = rd_idle & pick_lsu & lsu_rd_req_i.valid & lsu_is_tmr;

  always_comb
  begin
    axi_ar_o.addr  = ar_src.addr;
    axi_ar_o.size  = strb_to_size(ar_src.strb);
    axi_ar_o.valid = rd_idle & ar_src.valid & ~(pick_lsu & lsu_is_tmr);
  end

  always_comb
  begin
    timer_rd_req_o       = lsu_rd_req_i;
    timer_rd_req_o.valid = timer_go;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rd_owner_q    <= OWN_IDLE;
      ar_hold_q     <= 1'b0;
      ar_hold_lsu_q <= 1'b0;
    end
    else
    begin
      ar_hold_q     <= axi_ar_o.valid & ~axi_arready_i;
      ar_hold_lsu_q <= pick_lsu;
      case (rd_owner_q)
        OWN_IDLE:
        begin
          if (timer_go)
            rd_owner_q <= OWN_TMR;
          else if (axi_ar_o.valid && axi_arready_i)
            rd_owner_q <= pick_lsu ? OWN_LSU : OWN_IFU;
        end
        OWN_TMR:
        begin
          if (timer_rsp_i.done)
            rd_owner_q <= OWN_IDLE;
        end
        default:
        begin
          if (axi_r_i.valid)
            rd_owner_q <= OWN_IDLE;
        end
      endcase
    end
  end

  // owner still holds its address, so bit 2 picks the lane
  assign rd_lane_hi = (rd_owner_q == OWN_IFU) ? ifu_req_i.addr[2] : lsu_rd_req_i.addr[2];
  assign r_word     = rd_lane_hi ? axi_r_i.data[63:32] : axi_r_i.data[31:0];

  assign axi_rready_o = 1'b1;
  assign axi_bready_o = 1'b1;

  always_comb
  begin
    ifu_rsp_o.data    = r_word;
    ifu_rsp_o.done    = (rd_owner_q == OWN_IFU) & axi_r_i.valid;
    lsu_rd_rsp_o.data = (rd_owner_q == OWN_TMR) ? timer_rsp_i.data : r_word;
    lsu_rd_rsp_o.done = ((rd_owner_q == OWN_LSU) & axi_r_i.valid) |
                        ((rd_owner_q == OWN_TMR) & timer_rsp_i.done);
  end

  // stores: aw and w go out together, each drops on its own ready
  always_comb
  begin
    axi_aw_o.addr  = lsu_wr_req_i.addr;
    axi_aw_o.size  = strb_to_size(lsu_wr_req_i.strb);
    axi_aw_o.valid = wr_to_mem & ~aw_sent_q;
    axi_w_o.data   = {2{lsu_wr_req_i.data}};
    axi_w_o.strb   = lsu_wr_req_i.addr[2] ?
                     {lsu_wr_req_i.strb, {(`SOC_DATA_W/8){1'b0}}} :
                     {{(`SOC_DATA_W/8){1'b0}}, lsu_wr_req_i.strb};
    axi_w_o.last   = 1'b1;
    axi_w_o.valid  = wr_to_mem & ~w_sent_q;
  end

  always_comb
  begin
    uart_wr_o       = lsu_wr_req_i;
    uart_wr_o.valid = lsu_wr_req_i.valid & wr_is_uart;
  end

  assign lsu_wr_done_o = (wr_to_mem & axi_b_i.valid) | uart_done_i;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      aw_sent_q <= 1'b0;
      w_sent_q  <= 1'b0;
    end
    else if (wr_to_mem && axi_b_i.valid)
    begin
      aw_sent_q <= 1'b0;
      w_sent_q  <= 1'b0;
    end
    else
    begin
      if (axi_aw_o.valid && axi_awready_i)
        aw_sent_q <= 1'b1;
      if (axi_w_o.valid && axi_wready_i)
        w_sent_q <= 1'b1;
    end
  end

  // no error path on the memory side
  a_rresp_okay: assert property (@(posedge clk) disable iff (rst)
    axi_r_i.valid |-> axi_r_i.resp == `SOC_RESP_OKAY);

  a_bresp_okay: assert property (@(posedge clk) disable iff (rst)
    axi_b_i.valid |-> axi_b_i.resp == `SOC_RESP_OKAY);

  a_no_load_store: assert property (@(posedge clk) disable iff (rst)
    !(lsu_rd_req_i.valid && lsu_wr_req_i.valid));

  // byte, half or word only
  a_strb_legal: assert property (@(posedge clk) disable iff (rst)
    (ifu_req_i.valid -> ifu_req_i.strb inside {4'h1, 4'h3, 4'hf}) &&
    (lsu_rd_req_i.valid -> lsu_rd_req_i.strb inside {4'h1, 4'h3, 4'hf}) &&
    (lsu_wr_req_i.valid -> lsu_wr_req_i.strb inside {4'h1, 4'h3, 4'hf}));

endmodule

//--- source/clint_timer.sv
`include "soc_bus_defines.svh"

module clint_timer (
  input  logic                 clk,
  input  logic                 rst,
  input  soc_bus_pkg::rd_req_t rd_req_i,
  output soc_bus_pkg::rd_rsp_t rd_rsp_o
);

  logic [63:0]            mtime_q;
  logic [`SOC_DATA_W-1:0] rdata_q;
  logic                   busy_q;
  logic                   rd_start;

  // free-running machine time
  always_ff @(posedge clk)
  begin
    if (rst)
      mtime_q <= 64'd0;
    else
      mtime_q <= mtime_q + 64'd1;
  end

  // a held request starts only once
  assign rd_start = rd_req_i.valid & ~busy_q;

  always_ff @(posedge clk)
  begin
    if (rst)
      busy_q <= 1'b0;
    else if (rd_start)
      busy_q <= 1'b1;
    else if (busy_q)
      busy_q <= 1'b0;
  end

  // sample the half in the first cycle of the request
  always_ff @(posedge clk)
  begin
    if (rd_start)
    begin
      if (rd_req_i.addr == `SOC_RTC_ADDR_UP)
        rdata_q <= mtime_q[63:32];
      else
        rdata_q <= mtime_q[31:0];
    end
  end

  // done lands on the cycle after the start
  always_comb
  begin
    rd_rsp_o.data = rdata_q;
    rd_rsp_o.done = busy_q;
  end

  a_rtc_addr: assert property (@(posedge clk) disable iff (rst)
    rd_req_i.valid |-> (rd_req_i.addr == `SOC_RTC_ADDR) ||
                       (rd_req_i.addr == `SOC_RTC_ADDR_UP));

endmodule

//--- source/soc_bus_defines.svh
`ifndef SOC_BUS_DEFINES_SVH
`define SOC_BUS_DEFINES_SVH

// core side widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32

// external memory port, one 64-bit beat per transfer
`define SOC_AXI_DATA_W 64

// machine-time counter, low word then high word
`define SOC_RTC_ADDR 32'ha000_0048
`define SOC_RTC_ADDR_UP 32'ha000_004c

// serial transmit register, store only
`define SOC_SERIAL_ADDR 32'ha000_03f8

// axi response code for a good transfer
`define SOC_RESP_OKAY 2'b00

`endif

//--- source/soc_bus_pkg.sv
`include "soc_bus_defines.svh"

package soc_bus_pkg;

  // core read request, fetch or load
  typedef struct packed {
    logic [`SOC_ADDR_W-1:0]   addr;
    logic [`SOC_DATA_W/8-1:0] strb;
    logic                     valid;
  } rd_req_t;

  // whole 32-bit lane plus one-cycle done
  typedef struct packed {
    logic [`SOC_DATA_W-1:0] data;
    logic                   done;
  } rd_rsp_t;

  typedef struct packed {
    logic [`SOC_ADDR_W-1:0]   addr;
    logic [`SOC_DATA_W-1:0]   data;
    logic [`SOC_DATA_W/8-1:0] strb;
    logic                     valid;
  } wr_req_t;

  typedef struct packed {
    logic [`SOC_ADDR_W-1:0] addr;
    logic [2:0]             size;
    logic                   valid;
  } axi_ar_t;

  typedef struct packed {
    logic [`SOC_AXI_DATA_W-1:0] data;
    logic [1:0]                 resp;
    logic                       valid;
  } axi_r_t;

  typedef struct packed {
    logic [`SOC_ADDR_W-1:0] addr;
    logic [2:0]             size;
    logic                   valid;
  } axi_aw_t;

  typedef struct packed {
    logic [`SOC_AXI_DATA_W-1:0]   data;
    logic [`SOC_AXI_DATA_W/8-1:0] strb;
    logic                         last;
    logic                         valid;
  } axi_w_t;

  typedef struct packed {
    logic [1:0] resp;
    logic       valid;
  } axi_b_t;

  typedef struct packed {
    logic [7:0] data;
    logic       strobe;
  } uart_tx_t;

endpackage

//--- source/soc_bus_top.sv
module soc_bus_top (
  input  logic                  clk,
  input  logic                  rst,
  input  soc_bus_pkg::rd_req_t  ifu_req_i,
  output soc_bus_pkg::rd_rsp_t  ifu_rsp_o,
  input  soc_bus_pkg::rd_req_t  lsu_rd_req_i,
  output soc_bus_pkg::rd_rsp_t  lsu_rd_rsp_o,
  input  soc_bus_pkg::wr_req_t  lsu_wr_req_i,
  output logic                  lsu_wr_done_o,
  output soc_bus_pkg::axi_ar_t  axi_ar_o,
  input  logic                  axi_arready_i,
  input  soc_bus_pkg::axi_r_t   axi_r_i,
  output logic                  axi_rready_o,
  output soc_bus_pkg::axi_aw_t  axi_aw_o,
  input  logic                  axi_awready_i,
  output soc_bus_pkg::axi_w_t   axi_w_o,
  input  logic                  axi_wready_i,
  input  soc_bus_pkg::axi_b_t   axi_b_i,
  output logic                  axi_bready_o,
  output soc_bus_pkg::uart_tx_t uart_tx_o
);

  // local devices hang off the arbiter
  soc_bus_pkg::rd_req_t timer_rd_req;
  soc_bus_pkg::rd_rsp_t timer_rsp;
  soc_bus_pkg::wr_req_t uart_wr;
  logic                 uart_done;

  bus_arbiter u_arbiter (
    .clk            (clk),
    .rst            (rst),
    .ifu_req_i      (ifu_req_i),
    .ifu_rsp_o      (ifu_rsp_o),
    .lsu_rd_req_i   (lsu_rd_req_i),
    .lsu_rd_rsp_o   (lsu_rd_rsp_o),
    .lsu_wr_req_i   (lsu_wr_req_i),
    .lsu_wr_done_o  (lsu_wr_done_o),
    .axi_ar_o       (axi_ar_o),
    .axi_arready_i  (axi_arready_i),
    .axi_r_i        (axi_r_i),
    .axi_rready_o   (axi_rready_o),
    .axi_aw_o       (axi_aw_o),
    .axi_awready_i  (axi_awready_i),
    .axi_w_o        (axi_w_o),
    .axi_wready_i   (axi_wready_i),
    .axi_b_i        (axi_b_i),
    .axi_bready_o   (axi_bready_o),
    .timer_rd_req_o (timer_rd_req),
    .timer_rsp_i    (timer_rsp),
    .uart_wr_o      (uart_wr),
    .uart_done_i    (uart_done)
  );

  clint_timer u_timer (
    .clk      (clk),
    .rst      (rst),
    .rd_req_i (timer_rd_req),
    .rd_rsp_o (timer_rsp)
  );

  uart_tx_reg u_uart (
    .clk      (clk),
    .rst      (rst),
    .wr_req_i (uart_wr),
    .done_o   (uart_done),
    .tx_o     (uart_tx_o)
  );

endmodule

//--- source/uart_tx_reg.sv
module uart_tx_reg (
  input  logic                  clk,
  input  logic                  rst,
  input  soc_bus_pkg::wr_req_t  wr_req_i,
  output logic                  done_o,
  output soc_bus_pkg::uart_tx_t tx_o
);

  logic [7:0] byte_sel;
  logic [7:0] tx_data_q;
  logic       armed_q;
  logic       wr_start;

  // lowest set strobe bit names the byte lane
  always_comb
  begin
    if (wr_req_i.strb[0])
      byte_sel = wr_req_i.data[7:0];
    else if (wr_req_i.strb[1])
      byte_sel = wr_req_i.data[15:8];
    else if (wr_req_i.strb[2])
      byte_sel = wr_req_i.data[23:16];
    else
      byte_sel = wr_req_i.data[31:24];
  end

  // one capture per request even while valid stays up
  assign wr_start = wr_req_i.valid & ~armed_q;

  always_ff @(posedge clk)
  begin
    if (rst)
      armed_q <= 1'b0;
    else if (wr_start)
      armed_q <= 1'b1;
    else if (armed_q)
      armed_q <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (wr_start)
      tx_data_q <= byte_sel;
  end

  // strobe and done share the same pulse
  assign done_o = armed_q;

  always_comb
  begin
    tx_o.data   = tx_data_q;
    tx_o.strobe = armed_q;
  end

endmodule

//--- verif/tb_axi_mem.sv
module tb_axi_mem (
  input  logic                 clk,
  input  logic                 rst,
  input  soc_bus_pkg::axi_ar_t ar_i,
  output logic                 arready_o,
  output soc_bus_pkg::axi_r_t  r_o,
  input  soc_bus_pkg::axi_aw_t aw_i,
  output logic                 awready_o,
  input  soc_bus_pkg::axi_w_t  w_i,
  output logic                 wready_o,
  output soc_bus_pkg::axi_b_t  b_o
);

  integer      seed = 32'h1cf2_7041;
  logic [63:0] mem [logic [28:0]];
  logic [1:0]  rd_st;
  logic [1:0]  wr_st;
  logic [2:0]  rd_cnt;
  logic [2:0]  aw_cnt;
  logic [2:0]  w_cnt;
  logic [2:0]  b_cnt;
  logic        aw_done;
  logic        w_done;
  logic [28:0] rd_idx;

  // outputs idle from time zero, before the first reset edge
  initial
  begin
    arready_o = 1'b0;
    awready_o = 1'b0;
    wready_o  = 1'b0;
    r_o       = '0;
    b_o       = '0;
  end

  // unwritten memory reads back a pattern of its own address
  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return {a[15:0], a[31:16]} ^ 32'h3c3c_a5a5;
  endfunction

  function automatic logic [63:0] read_word(input logic [28:0] idx);
    if (mem.exists(idx))
      return mem[idx];
    return {fill_word({idx, 3'b100}), fill_word({idx, 3'b000})};
  endfunction

  function automatic logic [2:0] pick_delay();
    return 3'($unsigned($random(seed)) % 5);
  endfunction

  function automatic logic [63:0] merge_bytes(input logic [63:0] old,
                                              input logic [63:0] data,
                                              input logic [7:0]  strb);
    logic [63:0] word;
    word = old;
    for (int i = 0; i < 8; i++)
      if (strb[i])
        word[i*8 +: 8] = data[i*8 +: 8];
    return word;
  endfunction

  // read side: delay, arready, delay, one r beat
  always @(posedge clk)
  begin
    if (rst)
    begin
      rd_st     <= 2'd0;
      arready_o <= 1'b0;
      r_o       <= '0;
    end
    else
    begin
      case (rd_st)
        2'd0:
        begin
          r_o.valid <= 1'b0;
          if (ar_i.valid)
          begin
            rd_cnt <= pick_delay();
            rd_st  <= 2'd1;
          end
        end
        2'd1:
        begin
          if (rd_cnt == 3'd0)
          begin
            arready_o <= 1'b1;
            rd_st     <= 2'd2;
          end
          else
            rd_cnt <= rd_cnt - 3'd1;
        end
        2'd2:
        begin
          if (ar_i.valid)
          begin
            arready_o <= 1'b0;
            rd_idx    <= ar_i.addr[31:3];
            rd_cnt    <= pick_delay();
            rd_st     <= 2'd3;
          end
        end
        default:
        begin
          if (rd_cnt == 3'd0)
          begin
            r_o.valid <= 1'b1;
            r_o.resp  <= 2'b00;
            r_o.data  <= read_word(rd_idx);
            rd_st     <= 2'd0;
          end
          else
            rd_cnt <= rd_cnt - 3'd1;
        end
      endcase
    end
  end

  // write side: aw and w accepted on their own, then b after a delay
  always @(posedge clk)
  begin
    if (rst)
    begin
      wr_st     <= 2'd0;
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      b_o       <= '0;
    end
    else
    begin
      case (wr_st)
        2'd0:
        begin
          b_o.valid <= 1'b0;
          if (aw_i.valid)
          begin
            aw_cnt  <= pick_delay();
            w_cnt   <= pick_delay();
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            wr_st   <= 2'd1;
          end
        end
        2'd1:
        begin
          if (!aw_done)
          begin
            if (awready_o && aw_i.valid)
            begin
              awready_o <= 1'b0;
              aw_done   <= 1'b1;
            end
            else if (aw_cnt == 3'd0)
              awready_o <= 1'b1;
            else
              aw_cnt <= aw_cnt - 3'd1;
          end
          if (!w_done)
          begin
            if (wready_o && w_i.valid)
            begin
              wready_o <= 1'b0;
              w_done   <= 1'b1;
              mem[aw_i.addr[31:3]] = merge_bytes(read_word(aw_i.addr[31:3]), w_i.data, w_i.strb);
            end
            else if (w_cnt == 3'd0)
              wready_o <= 1'b1;
            else
              w_cnt <= w_cnt - 3'd1;
          end
          if (aw_done && w_done)
          begin
            b_cnt <= pick_delay();
            wr_st <= 2'd2;
          end
        end
        default:
        begin
          if (b_cnt == 3'd0)
          begin
            b_o.valid <= 1'b1;
            b_o.resp  <= 2'b00;
            wr_st     <= 2'd0;
          end
          else
            b_cnt <= b_cnt - 3'd1;
        end
      endcase
    end
  end

endmodule

//--- verif/tb_soc_bus.sv
`include "soc_bus_defines.svh"

module tb_soc_bus;

  logic                  clk = 1'b0;
  logic                  rst;
  soc_bus_pkg::rd_req_t  ifu_req;
  soc_bus_pkg::rd_rsp_t  ifu_rsp;
  soc_bus_pkg::rd_req_t  lsu_rd_req;
  soc_bus_pkg::rd_rsp_t  lsu_rd_rsp;
  soc_bus_pkg::wr_req_t  lsu_wr_req;
  logic                  lsu_wr_done;
  soc_bus_pkg::axi_ar_t  ar;
  soc_bus_pkg::axi_r_t   r;
  soc_bus_pkg::axi_aw_t  aw;
  soc_bus_pkg::axi_w_t   w;
  soc_bus_pkg::axi_b_t   b;
  soc_bus_pkg::uart_tx_t uart_tx;
  logic                  arready;
  logic                  awready;
  logic                  wready;
  logic                  rready;
  logic                  bready;
  integer                seed;
  logic [63:0]           mtime;
  logic [31:0]           model [logic [31:0]];
  logic [31:0]           last_lo;
  logic [63:0]           last_lo_time;

  always #50 clk = ~clk;

  // reference machine time, one tick per cycle out of reset
  always @(posedge clk)
  begin
    if (rst)
      mtime <= 64'd0;
    else
      mtime <= mtime + 64'd1;
  end

  soc_bus_top DUT (
    .clk           (clk),
    .rst           (rst),
    .ifu_req_i     (ifu_req),
    .ifu_rsp_o     (ifu_rsp),
    .lsu_rd_req_i  (lsu_rd_req),
    .lsu_rd_rsp_o  (lsu_rd_rsp),
    .lsu_wr_req_i  (lsu_wr_req),
    .lsu_wr_done_o (lsu_wr_done),
    .axi_ar_o      (ar),
    .axi_arready_i (arready),
    .axi_r_i       (r),
    .axi_rready_o  (rready),
    .axi_aw_o      (aw),
    .axi_awready_i (awready),
    .axi_w_o       (w),
    .axi_wready_i  (wready),
    .axi_b_i       (b),
    .axi_bready_o  (bready),
    .uart_tx_o     (uart_tx)
  );

  tb_axi_mem u_mem (
    .clk       (clk),
    .rst       (rst),
    .ar_i      (ar),
    .arready_o (arready),
    .r_o       (r),
    .aw_i      (aw),
    .awready_o (awready),
    .w_i       (w),
    .wready_o  (wready),
    .b_o       (b)
  );

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_rd_rsp(input string name, input soc_bus_pkg::rd_rsp_t exp,
                              input soc_bus_pkg::rd_rsp_t act);
    if (act !== exp)
      stop_run($sformatf("error %s: expected %h actual %h", name, exp, act));
  endtask

  task automatic check_uart(input string name, input soc_bus_pkg::uart_tx_t exp,
                            input soc_bus_pkg::uart_tx_t act);
    if (act !== exp)
      stop_run($sformatf("error %s: expected %h actual %h", name, exp, act));
  endtask

  task automatic check_axi_ar(input string name, input soc_bus_pkg::axi_ar_t exp,
                              input soc_bus_pkg::axi_ar_t act);
    if (act !== exp)
      stop_run($sformatf("error %s: expected %h actual %h", name, exp, act));
  endtask

  // address, size and byte strobe of a store's aw and w beats
  task automatic check_axi_aw(input string name,
                              input soc_bus_pkg::axi_aw_t exp_aw, input soc_bus_pkg::axi_w_t exp_w,
                              input soc_bus_pkg::axi_aw_t act_aw, input soc_bus_pkg::axi_w_t act_w);
    if ({act_aw.addr, act_aw.size, act_w.strb, act_w.last} !==
        {exp_aw.addr, exp_aw.size, exp_w.strb, exp_w.last})
      stop_run($sformatf("error %s: expected %h/%0d/%h/%b actual %h/%0d/%h/%b", name,
                         exp_aw.addr, exp_aw.size, exp_w.strb, exp_w.last,
                         act_aw.addr, act_aw.size, act_w.strb, act_w.last));
  endtask

  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return {a[15:0], a[31:16]} ^ 32'h3c3c_a5a5;
  endfunction

  function automatic logic [31:0] model_word(input logic [31:0] a);
    if (model.exists(a))
      return model[a];
    return fill_word(a);
  endfunction

  function automatic logic [2:0] size_of(input logic [3:0] strb);
    if (strb == 4'hf)
      return 3'd2;
    if (strb == 4'h3)
      return 3'd1;
    return 3'd0;
  endfunction

  task automatic check_idle();
    if ({ar.valid, aw.valid, w.valid, ifu_rsp.done, lsu_rd_rsp.done, lsu_wr_done,
         uart_tx.strobe} !== 7'd0)
      stop_run("bus output active with no request raised");
  endtask

  task automatic mem_store(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    soc_bus_pkg::wr_req_t  req;
    soc_bus_pkg::axi_aw_t  exp_aw;
    soc_bus_pkg::axi_w_t   exp_w;
    logic [31:0]           word;
    int                    n;
    logic                  seen;
    req.addr     = addr;
    req.data     = data;
    req.strb     = strb;
    req.valid    = 1'b1;
    exp_aw       = '0;
    exp_w        = '0;
    exp_aw.addr  = addr;
    exp_aw.size  = size_of(strb);
    exp_w.strb   = addr[2] ? {strb, 4'h0} : {4'h0, strb};
    exp_w.last   = 1'b1;
    n            = 0;
    seen         = 1'b0;
    @(posedge clk);
    lsu_wr_req <= req;
    do
    begin
      @(posedge clk);
      n++;
      if (aw.valid && !seen)
      begin
        check_axi_aw("store aw", exp_aw, exp_w, aw, w);
        seen = 1'b1;
      end
      if (n > 200)
        stop_run("timeout waiting for store done");
    end
    while (!lsu_wr_done);
    if (!seen)
      stop_run("store finished without an aw transfer");
    if (bready !== 1'b1)
      stop_run("bready low when the write response came back");
    lsu_wr_req.valid <= 1'b0;
    word = model_word(addr);
    for (int i = 0; i < 4; i++)
      if (strb[i])
        word[i*8 +: 8] = data[i*8 +: 8];
    model[addr] = word;
  endtask

  // a load and a fetch may be raised together and the load must win
  task automatic read_pair(input logic do_fetch, input logic do_load,
                           input logic [31:0] faddr, input logic [31:0] laddr,
                           input logic [3:0] lstrb);
    soc_bus_pkg::rd_rsp_t exp;
    soc_bus_pkg::axi_ar_t exp_ar;
    logic                 fdone;
    logic                 ldone;
    int                   n;
    fdone = !do_fetch;
    ldone = !do_load;
    n     = 0;
    exp.done = 1'b1;
    @(posedge clk);
    ifu_req    <= '{addr: faddr, strb: 4'hf, valid: do_fetch};
    lsu_rd_req <= '{addr: laddr, strb: lstrb, valid: do_load};
    do
    begin
      @(posedge clk);
      n++;
      // ar carries the load until the load is answered
      if (ar.valid)
      begin
        exp_ar.addr  = ldone ? faddr : laddr;
        exp_ar.size  = ldone ? 3'd2 : size_of(lstrb);
        exp_ar.valid = 1'b1;
        check_axi_ar("read ar", exp_ar, ar);
      end
      if (ifu_rsp.done)
      begin
        if (fdone)
          stop_run("fetch response with no fetch pending");
        if (!ldone)
          stop_run("fetch completed before the pending load");
        exp.data = model_word(faddr);
        check_rd_rsp("fetch", exp, ifu_rsp);
        fdone = 1'b1;
        ifu_req.valid <= 1'b0;
      end
      if (lsu_rd_rsp.done)
      begin
        if (ldone)
          stop_run("load response with no load pending");
        exp.data = model_word(laddr);
        check_rd_rsp("load", exp, lsu_rd_rsp);
        ldone = 1'b1;
        lsu_rd_req.valid <= 1'b0;
      end
      if (n > 200)
        stop_run("timeout waiting for read response");
    end
    while (!(fdone && ldone));
    if (rready !== 1'b1)
      stop_run("rready low when the read response came back");
  endtask

  task automatic timer_read(input logic hi);
    soc_bus_pkg::rd_rsp_t exp;
    logic [63:0]          t;
    @(posedge clk);
    lsu_rd_req <= '{addr: hi ? `SOC_RTC_ADDR_UP : `SOC_RTC_ADDR, strb: 4'hf, valid: 1'b1};
    @(posedge clk);
    t = mtime;
    if (lsu_rd_rsp.done || ar.valid)
      stop_run("timer read answered early or reached the memory port");
    @(posedge clk);
    exp.data = hi ? t[63:32] : t[31:0];
    exp.done = 1'b1;
    check_rd_rsp(hi ? "timer high" : "timer low", exp, lsu_rd_rsp);
    if (ar.valid || ifu_rsp.done)
      stop_run("timer read leaked onto the memory port or fetch port");
    lsu_rd_req.valid <= 1'b0;
    if (!hi)
    begin
      if (lsu_rd_rsp.data - last_lo < 32'(t - last_lo_time))
        stop_run("timer low word advanced less than elapsed cycles");
      last_lo      = lsu_rd_rsp.data;
      last_lo_time = t;
    end
  endtask

  task automatic serial_store(input logic [31:0] data, input logic [3:0] strb);
    soc_bus_pkg::uart_tx_t exp;
    exp.strobe = 1'b1;
    for (int i = 3; i >= 0; i--)
      if (strb[i])
        exp.data = data[i*8 +: 8];
    @(posedge clk);
    lsu_wr_req <= '{addr: `SOC_SERIAL_ADDR, data: data, strb: strb, valid: 1'b1};
    @(posedge clk);
    if (uart_tx.strobe || lsu_wr_done || aw.valid)
      stop_run("serial store answered early or reached the memory port");
    @(posedge clk);
    check_uart("uart byte", exp, uart_tx);
    if (!lsu_wr_done || aw.valid)
      stop_run("serial store done missing or aw raised");
    lsu_wr_req.valid <= 1'b0;
    @(posedge clk);
    if (uart_tx.strobe)
      stop_run("second uart strobe for one serial store");
  endtask

  initial
  begin
    logic [3:0] strb_tab [3];
    int         op;
    seed         = 32'h1cf2_7041;
    strb_tab     = '{4'h1, 4'h3, 4'hf};
    rst          = 1'b1;
    ifu_req      = '0;
    lsu_rd_req   = '0;
    lsu_wr_req   = '0;
    last_lo      = 32'd0;
    last_lo_time = 64'd0;
    @(posedge clk);
    @(negedge clk);
    check_idle();
    @(posedge clk);
    rst <= 1'b0;
    repeat (3)
    begin
      @(negedge clk);
      check_idle();
    end
    for (int i = 0; i < 120; i++)
    begin
      op = $unsigned($random(seed)) % 6;
      case (op)
        0, 1:
          mem_store(32'h2000 + 32'($unsigned($random(seed)) % 16) * 4, $random(seed),
                    strb_tab[$unsigned($random(seed)) % 3]);
        2:
          read_pair(1'b0, 1'b1, 32'h0, 32'h2000 + 32'($unsigned($random(seed)) % 16) * 4,
                    strb_tab[$unsigned($random(seed)) % 3]);
        3:
          read_pair(1'b1, 1'b1, 32'h2000 + 32'($unsigned($random(seed)) % 16) * 4,
                    32'h2000 + 32'($unsigned($random(seed)) % 16) * 4, 4'hf);
        4:
          timer_read(1'($random(seed)));
        default:
          serial_store($random(seed), strb_tab[$unsigned($random(seed)) % 3]);
      endcase
    end
    $display("TB PASSED");
    $finish;
  end

endmodule
